//--- include/tile_core_macros.svh
`ifndef TILE_CORE_MACROS_SVH
`define TILE_CORE_MACROS_SVH

// Network ID this core answers to
`define TC_NET_ID 10'd1

// Instruction memory address width, also the PC width
`define TC_IMEM_AW 8

// Register file address width
`define TC_RF_AW 4

// Barrier mask and value width
`define TC_MASK_W 8

// Datapath width
`define TC_DATA_W 32

`endif

//--- verilog/tile_core_pkg.sv
`include "tile_core_macros.svh"

package tile_core_pkg;

    //////////////////////////////
    // Instruction set
    //////////////////////////////

    // Zero is a no-op so a cleared stage decodes to a bubble
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_ADD   = 4'h1,
        OP_SUB   = 4'h2,
        OP_AND   = 4'h3,
        OP_OR    = 4'h4,
        OP_MOV   = 4'h5,
        OP_BEQZ  = 4'h6,
        OP_BNEQZ = 4'h7,
        OP_BAR   = 4'h8,
        OP_DONE  = 4'h9
    } opcode_e;

    // Low bits of rs_imm name rs, branches use it as a signed offset
    typedef struct packed {
        opcode_e               op;
        logic [`TC_RF_AW-1:0]  rd;
        logic [7:0]            rs_imm;
    } instr_s;

    //////////////////////////////
    // Network
    //////////////////////////////

    typedef enum logic [1:0] {NET_INSTR, NET_REG, NET_PC, NET_BAR} net_op_e;

    typedef struct packed {
        logic [9:0]            id;
        net_op_e               net_op;
        logic [9:0]            net_addr;
        logic [`TC_DATA_W-1:0] net_data;
    } net_packet_s;

    // Run state
    typedef enum logic [1:0] {IDLE, RUN, ERR} state_e;

    //////////////////////////////
    // Pipeline payloads
    //////////////////////////////

    typedef struct packed {
        logic writes_rf;
        logic is_branch;
        logic branch_on_zero;
        logic is_bar;
        logic is_done;
    } ctrl_s;

    // Fetch to decode
    typedef struct packed {
        instr_s                instr;
        logic [`TC_IMEM_AW-1:0] pc;
    } if_id_s;

    // Decode to execute
    typedef struct packed {
        instr_s                 instr;
        logic [`TC_IMEM_AW-1:0] pc;
        ctrl_s                  ctrl;
        logic [`TC_DATA_W-1:0]  rs_val;
        logic [`TC_DATA_W-1:0]  rd_val;
    } id_ex_s;

    // Execute to writeback
    typedef struct packed {
        instr_s                instr;
        ctrl_s                 ctrl;
        logic [`TC_DATA_W-1:0] result;
    } ex_wb_s;

    typedef struct packed {
        logic [`TC_IMEM_AW-1:0] pc;
        state_e                 state;
    } debug_s;

endpackage

//--- verilog/pipe_stage.sv
`timescale 1ns/100ps

// Pipeline register, one payload per cycle
module pipe_stage #(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     n_reset,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // A cleared payload has every control flag low and acts as a bubble
    always_ff @(posedge clk)
    begin
        if (!n_reset || flush_i)
        begin
            q_o <= '0;
        end
        else
        begin
            q_o <= d_i;
        end
    end

endmodule

//--- verilog/instr_mem.sv
`timescale 1ns/100ps
`include "tile_core_macros.svh"

module instr_mem (
    input  logic                    clk,
    input  logic                    we_i,
    input  logic [`TC_IMEM_AW-1:0]  waddr_i,
    input  tile_core_pkg::instr_s   wdata_i,
    input  logic [`TC_IMEM_AW-1:0]  raddr_i,
    output tile_core_pkg::instr_s   instr_o
);

    tile_core_pkg::instr_s mem [0:(1<<`TC_IMEM_AW)-1];

    // Network write port
    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            mem[waddr_i] <= wdata_i;
        end
        // Registered read, the caller presents next cycle's address
        instr_o <= mem[raddr_i];
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/100ps
`include "tile_core_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  we_i,
    input  logic [`TC_RF_AW-1:0]  waddr_i,
    input  logic [`TC_DATA_W-1:0] wdata_i,
    input  logic [`TC_RF_AW-1:0]  rs_addr_i,
    input  logic [`TC_RF_AW-1:0]  rd_addr_i,
    output logic [`TC_DATA_W-1:0] rs_o,
    output logic [`TC_DATA_W-1:0] rd_o
);

    logic [`TC_DATA_W-1:0] regs [0:(1<<`TC_RF_AW)-1];
    logic                  rs_hit;
    logic                  rd_hit;

    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write shows up on the read port
    assign rs_hit = we_i && (waddr_i == rs_addr_i);
    assign rd_hit = we_i && (waddr_i == rd_addr_i);

    // Register 0 reads as zero whatever was written to it
    assign rs_o = (rs_addr_i == '0) ? '0 : (rs_hit ? wdata_i : regs[rs_addr_i]);
    assign rd_o = (rd_addr_i == '0) ? '0 : (rd_hit ? wdata_i : regs[rd_addr_i]);

endmodule

//--- verilog/instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
    input  tile_core_pkg::instr_s instr_i,
    output tile_core_pkg::ctrl_s  ctrl_o
);

    always_comb
    begin
        // Unknown opcodes fall through as no-ops
        ctrl_o = '0;
        case (instr_i.op)
            tile_core_pkg::OP_ADD,
            tile_core_pkg::OP_SUB,
            tile_core_pkg::OP_AND,
            tile_core_pkg::OP_OR,
            tile_core_pkg::OP_MOV:
                ctrl_o.writes_rf = 1'b1;
            tile_core_pkg::OP_BEQZ:
            begin
                ctrl_o.is_branch      = 1'b1;
                ctrl_o.branch_on_zero = 1'b1;
            end
            tile_core_pkg::OP_BNEQZ:
                ctrl_o.is_branch = 1'b1;
            tile_core_pkg::OP_BAR:
                ctrl_o.is_bar = 1'b1;
            tile_core_pkg::OP_DONE:
                ctrl_o.is_done = 1'b1;
            default:
                ctrl_o = '0;
        endcase
    end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/100ps
`include "tile_core_macros.svh"

module execute_stage (
    input  tile_core_pkg::id_ex_s   id_ex_i,
    input  tile_core_pkg::ex_wb_s   ex_wb_r_i,
    output logic                    branch_taken_o,
    output logic [`TC_IMEM_AW-1:0]  branch_target_o,
    output tile_core_pkg::ex_wb_s   ex_wb_o
);

    logic [`TC_DATA_W-1:0] rs_val;
    logic [`TC_DATA_W-1:0] rd_val;
    logic [`TC_DATA_W-1:0] result;
    logic                  wb_valid;

    //////////////////////////////
    // Forwarding from writeback
    //////////////////////////////

    // Only a nonzero destination is worth forwarding
    assign wb_valid = ex_wb_r_i.ctrl.writes_rf && (ex_wb_r_i.instr.rd != '0);

    assign rs_val = (wb_valid && (ex_wb_r_i.instr.rd == id_ex_i.instr.rs_imm[`TC_RF_AW-1:0]))
                  ? ex_wb_r_i.result : id_ex_i.rs_val;
    assign rd_val = (wb_valid && (ex_wb_r_i.instr.rd == id_ex_i.instr.rd))
                  ? ex_wb_r_i.result : id_ex_i.rd_val;

    //////////////////////////////
    // ALU
    //////////////////////////////

    always_comb
    begin
        case (id_ex_i.instr.op)
            tile_core_pkg::OP_ADD: result = rd_val + rs_val;
            tile_core_pkg::OP_SUB: result = rd_val - rs_val;
            tile_core_pkg::OP_AND: result = rd_val & rs_val;
            tile_core_pkg::OP_OR:  result = rd_val | rs_val;
            // MOV and BAR both carry rs through
            tile_core_pkg::OP_MOV,
            tile_core_pkg::OP_BAR: result = rs_val;
            default:               result = '0;
        endcase
    end

    // Branch on rd, zero or nonzero as decode said
    assign branch_taken_o = id_ex_i.ctrl.is_branch
                          && ((rd_val == '0) == id_ex_i.ctrl.branch_on_zero);

    // Offset is signed and relative to the branch itself
    assign branch_target_o = id_ex_i.pc + `TC_IMEM_AW'($signed(id_ex_i.instr.rs_imm));

    assign ex_wb_o.instr  = id_ex_i.instr;
    assign ex_wb_o.ctrl   = id_ex_i.ctrl;
    assign ex_wb_o.result = result;

endmodule

//--- verilog/core_ctrl.sv
`timescale 1ns/100ps
`include "tile_core_macros.svh"

module core_ctrl (
    input  logic                        clk,
    input  logic                        n_reset,
    input  tile_core_pkg::net_packet_s  net_packet_i,
    input  tile_core_pkg::ex_wb_s       ex_wb_i,
    output logic                        imem_we_o,
    output logic                        rf_net_we_o,
    output logic                        pc_load_o,
    output logic                        flush_all_o,
    output tile_core_pkg::state_e       state_o,
    output logic [`TC_MASK_W-1:0]       barrier_o,
    output logic                        exception_o
);

    tile_core_pkg::state_e state_r;
    tile_core_pkg::state_e state_n;
    logic [`TC_MASK_W-1:0] mask_r;
    logic [`TC_MASK_W-1:0] barrier_r;
    logic                  exception_r;
    logic                  id_match;
    logic                  in_idle;
    logic                  net_pc;
    logic                  net_bar;
    logic                  pc_bad;

    //////////////////////////////
    // Network command decode
    //////////////////////////////

    // Packets for other cores carry no command
    assign id_match = (net_packet_i.id == `TC_NET_ID);
    assign in_idle  = (state_r == tile_core_pkg::IDLE);

    assign net_pc  = id_match && (net_packet_i.net_op == tile_core_pkg::NET_PC);
    assign net_bar = id_match && (net_packet_i.net_op == tile_core_pkg::NET_BAR);

    // Memory and register loads only while idle
    assign imem_we_o   = id_match && (net_packet_i.net_op == tile_core_pkg::NET_INSTR) && in_idle;
    assign rf_net_we_o = id_match && (net_packet_i.net_op == tile_core_pkg::NET_REG) && in_idle;
    assign pc_load_o   = net_pc && in_idle;
    // PC write while busy is an error
    assign pc_bad      = net_pc && !in_idle;

    // Start of a run or DONE committing clears the pipe
    assign flush_all_o = pc_load_o || ex_wb_i.ctrl.is_done;

    //////////////////////////////
    // Run state
    //////////////////////////////

    always_comb
    begin
        state_n = state_r;
        if (pc_bad)
            state_n = tile_core_pkg::ERR;
        else if (pc_load_o)
            state_n = tile_core_pkg::RUN;
        else if ((state_r == tile_core_pkg::RUN) && ex_wb_i.ctrl.is_done)
            state_n = tile_core_pkg::IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r     <= tile_core_pkg::IDLE;
            mask_r      <= '0;
            barrier_r   <= '0;
            exception_r <= 1'b0;
        end
        else
        begin
            state_r <= state_n;
            // Mask is frozen once in ERR
            if (net_bar && (state_r != tile_core_pkg::ERR))
                mask_r <= net_packet_i.net_data[`TC_MASK_W-1:0];
            // PC load seeds the barrier, BAR in writeback overwrites it
            if (pc_load_o)
                barrier_r <= net_packet_i.net_data[`TC_MASK_W-1:0];
            else if (ex_wb_i.ctrl.is_bar)
                barrier_r <= ex_wb_i.result[`TC_MASK_W-1:0];
            // Sticky until reset
            if (pc_bad)
                exception_r <= 1'b1;
        end
    end

    assign state_o     = state_r;
    assign barrier_o   = mask_r & barrier_r;
    assign exception_o = exception_r;

endmodule

//--- verilog/tile_core.sv
`timescale 1ns/100ps
`include "tile_core_macros.svh"

module tile_core (
    input  logic                        clk,
    input  logic                        n_reset,
    input  tile_core_pkg::net_packet_s  net_packet_i,
    output logic [`TC_MASK_W-1:0]       barrier_o,
    output logic                        exception_o,
    output tile_core_pkg::debug_s       debug_o
);

    logic                   imem_we;
    logic                   rf_net_we;
    logic                   pc_load;
    logic                   flush_all;
    tile_core_pkg::state_e  state;
    logic [`TC_IMEM_AW-1:0] pc_r;
    logic [`TC_IMEM_AW-1:0] pc_n;
    logic [`TC_IMEM_AW-1:0] imem_addr;
    logic                   branch_taken;
    logic [`TC_IMEM_AW-1:0] branch_target;
    tile_core_pkg::instr_s  imem_out;
    tile_core_pkg::ctrl_s   ctrl;
    logic [`TC_DATA_W-1:0]  rs_val;
    logic [`TC_DATA_W-1:0]  rd_val;
    logic                   rf_we;
    logic [`TC_RF_AW-1:0]   rf_waddr;
    logic [`TC_DATA_W-1:0]  rf_wdata;
    logic                   run;
    logic                   flush_front;
    tile_core_pkg::if_id_s  if_id_n, if_id_r;
    tile_core_pkg::id_ex_s  id_ex_n, id_ex_r;
    tile_core_pkg::ex_wb_s  ex_wb_n, ex_wb_r;

    core_ctrl ctrl_i (
        .clk(clk),
        .n_reset(n_reset),
        .net_packet_i(net_packet_i),
        .ex_wb_i(ex_wb_r),
        .imem_we_o(imem_we),
        .rf_net_we_o(rf_net_we),
        .pc_load_o(pc_load),
        .flush_all_o(flush_all),
        .state_o(state),
        .barrier_o(barrier_o),
        .exception_o(exception_o)
    );

    assign run = (state == tile_core_pkg::RUN);

    //////////////////////////////
    // PC and fetch
    //////////////////////////////

    // Network load wins, then a taken branch, else step
    always_comb
    begin
        if (pc_load)
            pc_n = net_packet_i.net_addr[`TC_IMEM_AW-1:0];
        else if (!run)
            pc_n = pc_r;
        else if (branch_taken)
            pc_n = branch_target;
        else
            pc_n = pc_r + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            pc_r <= '0;
        else
            pc_r <= pc_n;
    end

    // Memory sees next PC so its output lines up with pc_r
    assign imem_addr = imem_we ? net_packet_i.net_addr[`TC_IMEM_AW-1:0] : pc_n;

    instr_mem imem_i (
        .clk(clk),
        .we_i(imem_we),
        .waddr_i(imem_addr),
        .wdata_i(tile_core_pkg::instr_s'(net_packet_i.net_data[$bits(tile_core_pkg::instr_s)-1:0])),
        .raddr_i(imem_addr),
        .instr_o(imem_out)
    );

    // Outside RUN fetch only feeds bubbles
    assign if_id_n = run ? {imem_out, pc_r} : '0;

    // Taken branch kills fetch and decode
    assign flush_front = flush_all || branch_taken;

    pipe_stage #(.payload_t(tile_core_pkg::if_id_s)) if_id_i (
        .clk(clk),
        .n_reset(n_reset),
        .flush_i(flush_front),
        .d_i(if_id_n),
        .q_o(if_id_r)
    );

    //////////////////////////////
    // Decode and register read
    //////////////////////////////

    instr_decode decode_i (
        .instr_i(if_id_r.instr),
        .ctrl_o(ctrl)
    );

    reg_file rf_i (
        .clk(clk),
        .we_i(rf_we),
        .waddr_i(rf_waddr),
        .wdata_i(rf_wdata),
        .rs_addr_i(if_id_r.instr.rs_imm[`TC_RF_AW-1:0]),
        .rd_addr_i(if_id_r.instr.rd),
        .rs_o(rs_val),
        .rd_o(rd_val)
    );

    assign id_ex_n = {if_id_r.instr, if_id_r.pc, ctrl, rs_val, rd_val};

    pipe_stage #(.payload_t(tile_core_pkg::id_ex_s)) id_ex_i (
        .clk(clk),
        .n_reset(n_reset),
        .flush_i(flush_front),
        .d_i(id_ex_n),
        .q_o(id_ex_r)
    );

    //////////////////////////////
    // Execute and writeback
    //////////////////////////////

    execute_stage exec_i (
        .id_ex_i(id_ex_r),
        .ex_wb_r_i(ex_wb_r),
        .branch_taken_o(branch_taken),
        .branch_target_o(branch_target),
        .ex_wb_o(ex_wb_n)
    );

    pipe_stage #(.payload_t(tile_core_pkg::ex_wb_s)) ex_wb_i (
        .clk(clk),
        .n_reset(n_reset),
        .flush_i(flush_all),
        .d_i(ex_wb_n),
        .q_o(ex_wb_r)
    );

    // Network owns the write port in IDLE, writeback otherwise
    assign rf_we    = rf_net_we || ex_wb_r.ctrl.writes_rf;
    assign rf_waddr = (state == tile_core_pkg::IDLE)
                    ? net_packet_i.net_addr[`TC_RF_AW-1:0] : ex_wb_r.instr.rd;
    assign rf_wdata = (state == tile_core_pkg::IDLE) ? net_packet_i.net_data : ex_wb_r.result;

    assign debug_o.pc    = pc_r;
    assign debug_o.state = state;

endmodule

//--- dv/tile_core_tb.sv
`timescale 1ns/100ps
`include "tile_core_macros.svh"

module tile_core_tb;

    localparam int NUM_WORDS = 14;
    localparam int MAX_CASES = 8;
    localparam int RUN_LIMIT = 200;

    // One stimulus row with its expected barrier
    typedef struct packed {
        logic [`TC_DATA_W-1:0] r1;
        logic [`TC_DATA_W-1:0] r2;
        logic [`TC_DATA_W-1:0] r5;
        logic [`TC_MASK_W-1:0] mask;
        logic [`TC_DATA_W-1:0] pc_data;
        logic [`TC_MASK_W-1:0] exp_barrier;
    } case_s;

    logic                       clk;
    logic                       n_reset;
    tile_core_pkg::net_packet_s net_packet;
    logic [`TC_MASK_W-1:0]      barrier;
    logic                       exception;
    tile_core_pkg::debug_s      debug;

    tile_core_pkg::instr_s      program_rom [0:NUM_WORDS-1];
    case_s                      cases [0:MAX_CASES-1];
    string                      case_names [0:MAX_CASES-1];
    int                         num_cases;
    int                         num_checks;
    int                         num_errors;

    tile_core dut_i (
        .clk(clk),
        .n_reset(n_reset),
        .net_packet_i(net_packet),
        .barrier_o(barrier),
        .exception_o(exception),
        .debug_o(debug)
    );

    // 20 ns clock
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic tile_core_pkg::instr_s encode_instr(
        input tile_core_pkg::opcode_e op,
        input logic [`TC_RF_AW-1:0]   rd,
        input logic [7:0]             rs_imm
    );
        tile_core_pkg::instr_s instr;
        instr.op     = op;
        instr.rd     = rd;
        instr.rs_imm = rs_imm;
        return instr;
    endfunction

    // Packet addressed to this core
    function automatic tile_core_pkg::net_packet_s build_packet(
        input tile_core_pkg::net_op_e net_op,
        input logic [9:0]             addr,
        input logic [`TC_DATA_W-1:0]  data
    );
        tile_core_pkg::net_packet_s pkt;
        pkt.id       = `TC_NET_ID;
        pkt.net_op   = net_op;
        pkt.net_addr = addr;
        pkt.net_data = data;
        return pkt;
    endfunction

    // One-cycle strobe, then an idle packet for another ID
    task automatic send_packet(input tile_core_pkg::net_packet_s pkt);
        @(posedge clk);
        net_packet <= pkt;
        @(posedge clk);
        net_packet <= '0;
    endtask

    task automatic wait_for_idle(output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && (cycles < RUN_LIMIT))
        begin
            @(negedge clk);
            cycles++;
            if (debug.state == tile_core_pkg::IDLE)
                ok = 1'b1;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error: %s: expected %h, actual %h", name, exp, act);
        num_errors++;
    endtask

    task automatic add_case(input string name, input logic [31:0] r1, input logic [31:0] r2,
                            input logic [31:0] r5, input logic [7:0] mask,
                            input logic [31:0] pc_data, input logic [7:0] exp_barrier);
        case_names[num_cases]        = name;
        cases[num_cases].r1          = r1;
        cases[num_cases].r2          = r2;
        cases[num_cases].r5          = r5;
        cases[num_cases].mask        = mask;
        cases[num_cases].pc_data     = pc_data;
        cases[num_cases].exp_barrier = exp_barrier;
        num_cases++;
    endtask

    //////////////////////////////
    // Program and case table
    //////////////////////////////

    task automatic fill_program_table();
        // Dependent pairs lean on forwarding and write-through
        program_rom[0]  = encode_instr(tile_core_pkg::OP_MOV, 4'd3, 8'd1);
        program_rom[1]  = encode_instr(tile_core_pkg::OP_ADD, 4'd3, 8'd2);
        program_rom[2]  = encode_instr(tile_core_pkg::OP_MOV, 4'd4, 8'd3);
        program_rom[3]  = encode_instr(tile_core_pkg::OP_SUB, 4'd4, 8'd1);
        // Skips the OR when r5 is zero
        program_rom[4]  = encode_instr(tile_core_pkg::OP_BEQZ, 4'd5, 8'd2);
        program_rom[5]  = encode_instr(tile_core_pkg::OP_OR, 4'd3, 8'd2);
        program_rom[6]  = encode_instr(tile_core_pkg::OP_MOV, 4'd6, 8'd3);
        program_rom[7]  = encode_instr(tile_core_pkg::OP_AND, 4'd6, 8'd4);
        // r0 reads zero so this never branches
        program_rom[8]  = encode_instr(tile_core_pkg::OP_BNEQZ, 4'd0, 8'hF8);
        program_rom[9]  = encode_instr(tile_core_pkg::OP_BAR, 4'd0, 8'd6);
        program_rom[10] = encode_instr(tile_core_pkg::OP_DONE, 4'd0, 8'd0);
        // Padding fetched behind DONE
        program_rom[11] = encode_instr(tile_core_pkg::OP_NOP, 4'd0, 8'd0);
        program_rom[12] = encode_instr(tile_core_pkg::OP_NOP, 4'd0, 8'd0);
        program_rom[13] = encode_instr(tile_core_pkg::OP_NOP, 4'd0, 8'd0);

        // r6 = (r5 ? (r1+r2)|r2 : r1+r2) & r2, low byte ANDed with the mask
        add_case("taken_mask_ff", 32'd7, 32'd5, 32'd0, 8'hFF, 32'h3C, 8'h04);
        add_case("not_taken_mask_ff", 32'd7, 32'd5, 32'd1, 8'hFF, 32'h81, 8'h05);
        add_case("not_taken_mask_0f", 32'h37, 32'hF6, 32'd9, 8'h0F, 32'h5A, 8'h06);
        add_case("taken_mask_00", 32'h20, 32'h13, 32'd0, 8'h00, 32'hFF, 8'h00);
        add_case("wrap_mask_ff", 32'h8000_0001, 32'h7FFF_FFFF, 32'h100, 8'hFF, 32'h00, 8'hFF);
    endtask

    task automatic run_case(input int i);
        logic                  ok;
        logic [`TC_MASK_W-1:0] seed_exp;
        seed_exp = cases[i].pc_data[`TC_MASK_W-1:0] & cases[i].mask;
        send_packet(build_packet(tile_core_pkg::NET_REG, 10'd1, cases[i].r1));
        send_packet(build_packet(tile_core_pkg::NET_REG, 10'd2, cases[i].r2));
        send_packet(build_packet(tile_core_pkg::NET_REG, 10'd5, cases[i].r5));
        send_packet(build_packet(tile_core_pkg::NET_BAR, 10'd0, {24'd0, cases[i].mask}));
        send_packet(build_packet(tile_core_pkg::NET_PC, 10'd0, cases[i].pc_data));

        // Two edges after the PC packet, long before BAR commits
        @(posedge clk);
        @(negedge clk);
        num_checks++;
        if (barrier !== seed_exp)
            report_mismatch({case_names[i], "_seed"}, seed_exp, barrier);
        num_checks++;
        if (debug.state !== tile_core_pkg::RUN)
            report_mismatch({case_names[i], "_run"}, tile_core_pkg::RUN, debug.state);

        wait_for_idle(ok);
        if (!ok)
        begin
            $display("%s: core never returned to IDLE after DONE", case_names[i]);
            num_errors++;
        end
        else
        begin
            num_checks++;
            if (barrier !== cases[i].exp_barrier)
                report_mismatch(case_names[i], cases[i].exp_barrier, barrier);
            num_checks++;
            if (exception !== 1'b0)
                report_mismatch({case_names[i], "_exc"}, 1'b0, exception);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        n_reset    = 1'b0;
        net_packet = '0;
        num_cases  = 0;
        num_checks = 0;
        num_errors = 0;
        fill_program_table();

        repeat (5) @(posedge clk);
        n_reset <= 1'b1;
        @(negedge clk);
        num_checks++;
        if ((barrier !== '0) || (exception !== 1'b0) || (debug !== '0))
        begin
            $display("Outputs were not cleared by reset");
            num_errors++;
        end

        for (int w = 0; w < NUM_WORDS; w++)
            send_packet(build_packet(tile_core_pkg::NET_INSTR, w[9:0], {16'd0, program_rom[w]}));

        for (int i = 0; i < num_cases; i++)
            run_case(i);

        // Second PC write lands while the first run is still going
        send_packet(build_packet(tile_core_pkg::NET_PC, 10'd0, 32'd0));
        @(negedge clk);
        num_checks++;
        if (debug.state !== tile_core_pkg::RUN)
            report_mismatch("pc_busy_run", tile_core_pkg::RUN, debug.state);
        send_packet(build_packet(tile_core_pkg::NET_PC, 10'd0, 32'd0));
        @(negedge clk);
        num_checks++;
        if (exception !== 1'b1)
            report_mismatch("pc_busy_exc", 1'b1, exception);
        num_checks++;
        if (debug.state !== tile_core_pkg::ERR)
            report_mismatch("pc_busy_err", tile_core_pkg::ERR, debug.state);

        $display("Checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tile_core.f
+incdir+include
verilog/tile_core_pkg.sv
verilog/pipe_stage.sv
verilog/instr_mem.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/execute_stage.sv
verilog/core_ctrl.sv
verilog/tile_core.sv
dv/tile_core_tb.sv
